/* matmul_engine.f */
hdl/matmul_pkg.sv
hdl/mac_pe.sv
hdl/systolic_array.sv
hdl/matmul_sequencer.sv
hdl/multi_matmul.sv
hdl/multi_matmul_wrapper.sv
hdl/matmul_engine.sv
sim/matmul_tb.sv

/* sim/matmul_tb.sv */
`timescale 1ns/1ps
// Random-stimulus testbench for matmul_engine
// Streams operand beats, models each tile in integer math and compares every result element
module matmul_tb;
    import matmul_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int FIX_MAX        = (1 <<< (WIDTH - 1)) - 1;
    localparam int FIX_MIN        = -(1 <<< (WIDTH - 1));

    logic        clk;
    logic        arst_n;
    logic        en;
    logic        reset_acc;
    west_bus_t   west;
    north_bus_t  north;
    engine_out_t result;
    logic        acc_done;
    logic        systolic_finish;

    int a_op [TOTAL_INPUT_W][CHUNK_SIZE][INNER_DIMENSION];  // A by group, row and beat
    int b_op [TOTAL_MODULES][CHUNK_SIZE][INNER_DIMENSION];  // B by module, column and beat

    matmul_engine i_matmul_engine (
        .clk             (clk),
        .arst_n          (arst_n),
        .en              (en),
        .reset_acc       (reset_acc),
        .west            (west),
        .north           (north),
        .result          (result),
        .acc_done        (acc_done),
        .systolic_finish (systolic_finish)
    );

    always #10 clk = ~clk;

    // Reference value of one tile element, computed straight from the operand arrays
    function automatic int expected_elem(int g, int m, int r, int c);
        longint sum;
        sum = 0;
        for (int k = 0; k < INNER_DIMENSION; k++) begin
            sum += longint'(a_op[g][r][k]) * longint'(b_op[m][c][k]);
        end
        sum = sum >>> FRAC_WIDTH;  // Q16.16 sum down to Q8.8, rounding toward minus infinity
        if (sum > FIX_MAX) begin
            return FIX_MAX;
        end else if (sum < FIX_MIN) begin
            return FIX_MIN;
        end
        return int'(sum);
    endfunction

    // Mode 0 gives small values, mode 1 large positive, mode 2 large with B negated
    function automatic int pick_operand(int mode, bit is_b);
        case (mode)
            1: return int'($urandom_range(16384, 32767));
            2: begin
                if (is_b) begin
                    return -int'($urandom_range(16384, 32768));
                end
                return int'($urandom_range(16384, 32767));
            end
            default: return int'($urandom_range(0, 1023)) - 512;  // About +-2.0 in Q8.8
        endcase
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(string name, int expected, int actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fill_operands(int mode);
        for (int k = 0; k < INNER_DIMENSION; k++) begin
            for (int g = 0; g < TOTAL_INPUT_W; g++) begin
                for (int r = 0; r < CHUNK_SIZE; r++) begin
                    a_op[g][r][k] = pick_operand(mode, 1'b0);
                end
            end
            for (int m = 0; m < TOTAL_MODULES; m++) begin
                for (int c = 0; c < CHUNK_SIZE; c++) begin
                    b_op[m][c][k] = pick_operand(mode, 1'b1);
                end
            end
        end
    endtask

    // Feeds all beats of the model, optionally with idle cycles carrying junk data
    task automatic drive_beats(string name, bit gaps);
        west_bus_t  w;
        north_bus_t n;
        int         idle;
        for (int k = 0; k < INNER_DIMENSION; k++) begin
            idle = gaps ? int'($urandom_range(0, 3)) : 0;
            repeat (idle) begin
                @(posedge clk);
                en    <= 1'b0;
                west  <= {$urandom(), $urandom()};  // Must be ignored while en is low
                north <= {$urandom(), $urandom()};
            end
            for (int g = 0; g < TOTAL_INPUT_W; g++) begin
                for (int r = 0; r < CHUNK_SIZE; r++) begin
                    w.chunk[g].elem[r] = fixed_t'(a_op[g][r][k]);
                end
            end
            for (int m = 0; m < TOTAL_MODULES; m++) begin
                for (int c = 0; c < CHUNK_SIZE; c++) begin
                    n.chunk[m].elem[c] = fixed_t'(b_op[m][c][k]);
                end
            end
            @(posedge clk);
            en    <= 1'b1;
            west  <= w;
            north <= n;
            @(negedge clk);
            compare_value({name, " acc_done before last beat"}, 0, int'(acc_done));
        end
        @(posedge clk);
        en <= 1'b0;  // This edge takes the final beat
        @(negedge clk);
        compare_value({name, " acc_done on last beat"}, 1, int'(acc_done));
    endtask

    task automatic wait_finish(string name);
        int cycles;
        cycles = 0;
        while (!systolic_finish) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run({name, ": systolic_finish did not rise after acc_done"});
            end
        end
        compare_value({name, " drain cycles"}, DRAIN_CYCLES, cycles);
    endtask

    task automatic verify_tiles(string name, bit expect_zero);
        int expected;
        int actual;
        for (int g = 0; g < TOTAL_INPUT_W; g++) begin
            for (int m = 0; m < TOTAL_MODULES; m++) begin
                for (int r = 0; r < CHUNK_SIZE; r++) begin
                    for (int c = 0; c < CHUNK_SIZE; c++) begin
                        expected = expect_zero ? 0 : expected_elem(g, m, r, c);
                        actual   = $signed(result.grp[g].tile[m].elem[r][c]);
                        compare_value($sformatf("%s g%0d m%0d r%0d c%0d", name, g, m, r, c),
                                      expected, actual);
                    end
                end
            end
        end
    endtask

    task automatic clear_accumulators(string name);
        @(posedge clk);
        en        <= 1'b0;
        reset_acc <= 1'b1;
        @(posedge clk);
        reset_acc <= 1'b0;
        @(negedge clk);
        compare_value({name, " acc_done"}, 0, int'(acc_done));
        compare_value({name, " systolic_finish"}, 0, int'(systolic_finish));
        verify_tiles(name, 1'b1);
    endtask

    initial begin
        int unsigned seed_ret;
        engine_out_t snapshot;
        seed_ret  = $urandom(65);
        clk       = 1'b0;
        arst_n    = 1'b0;
        en        = 1'b0;
        reset_acc = 1'b0;
        west      = '0;
        north     = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        compare_value("reset_state acc_done", 0, int'(acc_done));
        compare_value("reset_state systolic_finish", 0, int'(systolic_finish));
        verify_tiles("reset_state", 1'b1);

        fill_operands(0);
        drive_beats("small_product", 1'b0);
        wait_finish("small_product");
        verify_tiles("small_product", 1'b0);
        clear_accumulators("small_product clear");

        fill_operands(1);
        drive_beats("saturation_high", 1'b0);
        wait_finish("saturation_high");
        verify_tiles("saturation_high", 1'b0);
        compare_value("saturation_high clamp", FIX_MAX, $signed(result.grp[0].tile[0].elem[0][0]));
        clear_accumulators("saturation_high clear");

        fill_operands(2);
        drive_beats("saturation_low", 1'b1);
        wait_finish("saturation_low");
        verify_tiles("saturation_low", 1'b0);
        compare_value("saturation_low clamp", FIX_MIN, $signed(result.grp[1].tile[1].elem[1][1]));
        clear_accumulators("saturation_low clear");

        fill_operands(0);
        drive_beats("idle_gaps", 1'b1);
        wait_finish("idle_gaps");
        verify_tiles("idle_gaps", 1'b0);

        // Beats offered after completion must leave the finished tiles alone
        snapshot = result;
        repeat (4) begin
            @(posedge clk);
            en    <= 1'b1;
            west  <= {$urandom(), $urandom()};
            north <= {$urandom(), $urandom()};
        end
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        assert (result == snapshot) else begin
            $display("CHECK FAILED ignored_and_cleared expected %h actual %h", snapshot, result);
            $display("test failed");
            $fatal(1, "result changed after completion");
        end
        compare_value("ignored_and_cleared acc_done", 1, int'(acc_done));
        compare_value("ignored_and_cleared systolic_finish", 1, int'(systolic_finish));
        clear_accumulators("ignored_and_cleared clear");

        fill_operands(0);
        drive_beats("ignored_and_cleared rerun", 1'b1);
        wait_finish("ignored_and_cleared rerun");
        verify_tiles("ignored_and_cleared rerun", 1'b0);

        $display("test passed");
        $finish;
    end

endmodule

/* hdl/matmul_engine.sv */
`timescale 1ns/1ps
// Top level of the streaming matmul engine
// Feed one west and one north beat per en cycle and read result once systolic_finish is high
module matmul_engine (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    en,
    input  logic                    reset_acc,
    input  matmul_pkg::west_bus_t   west,
    input  matmul_pkg::north_bus_t  north,
    output matmul_pkg::engine_out_t result,
    output logic                    acc_done,
    output logic                    systolic_finish
);

    multi_matmul_wrapper wrapper_inst (
        .clk                  (clk),
        .arst_n               (arst_n),
        .en                   (en),
        .reset_acc            (reset_acc),
        .in_bram              (west),
        .input_n              (north),
        .out_multi_matmul     (result),
        .acc_done_wrap        (acc_done),
        .systolic_finish_wrap (systolic_finish)
    );

endmodule

/* hdl/multi_matmul_wrapper.sv */
`timescale 1ns/1ps
// TOTAL_INPUT_W groups that all see the same north bus, each with its own west chunk
// A flag is reported only once every group has raised it
module multi_matmul_wrapper (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    en,
    input  logic                    reset_acc,
    input  matmul_pkg::west_bus_t   in_bram,
    input  matmul_pkg::north_bus_t  input_n,
    output matmul_pkg::engine_out_t out_multi_matmul,
    output logic                    acc_done_wrap,
    output logic                    systolic_finish_wrap
);
    import matmul_pkg::*;

    logic [TOTAL_INPUT_W-1:0] acc_done_array;
    logic [TOTAL_INPUT_W-1:0] systolic_finish_array;

    for (genvar g = 0; g < TOTAL_INPUT_W; g++) begin : gen_wrapper
        multi_matmul multi_matmul_inst (
            .clk              (clk),
            .arst_n           (arst_n),
            .en               (en),
            .reset_acc        (reset_acc),
            .input_w          (in_bram.chunk[g]),        // Row-chunk for this group
            .input_n          (input_n),
            .out_multi_matmul (out_multi_matmul.grp[g]),
            .accumulator_done (acc_done_array[g]),
            .systolic_finish  (systolic_finish_array[g])
        );
    end

    assign acc_done_wrap        = &acc_done_array;
    assign systolic_finish_wrap = &systolic_finish_array;

endmodule

/* hdl/multi_matmul.sv */
`timescale 1ns/1ps
// One west group: TOTAL_MODULES arrays fed the same row-chunk of A
// Array m takes column-chunk m of the north bus and produces tile m of the group
module multi_matmul (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic                   reset_acc,
    input  matmul_pkg::chunk_vec_t input_w,
    input  matmul_pkg::north_bus_t input_n,
    output matmul_pkg::group_out_t out_multi_matmul,
    output logic                   accumulator_done,
    output logic                   systolic_finish
);
    import matmul_pkg::*;

    logic clear;
    logic advance;
    logic zero_fill;

    matmul_sequencer sequencer_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .en              (en),
        .reset_acc       (reset_acc),
        .clear           (clear),
        .advance         (advance),
        .zero_fill       (zero_fill),
        .acc_done        (accumulator_done),
        .systolic_finish (systolic_finish)
    );

    for (genvar m = 0; m < TOTAL_MODULES; m++) begin : gen_array
        systolic_array array_inst (
            .clk       (clk),
            .arst_n    (arst_n),
            .clear     (clear),
            .advance   (advance),
            .zero_fill (zero_fill),
            .west_vec  (input_w),                  // Shared by every array in the group
            .north_vec (input_n.chunk[m]),
            .tile      (out_multi_matmul.tile[m])
        );
    end

endmodule

/* hdl/matmul_sequencer.sv */
`timescale 1ns/1ps
// Beat and drain control shared by all arrays of one group
// Accepts INNER_DIMENSION beats, then drives DRAIN_CYCLES zero-filled advances
module matmul_sequencer (
    input  logic clk,
    input  logic arst_n,
    input  logic en,
    input  logic reset_acc,
    output logic clear,
    output logic advance,
    output logic zero_fill,
    output logic acc_done,
    output logic systolic_finish
);
    import matmul_pkg::*;

    logic [BEAT_CNT_W-1:0]  beat_cnt;
    logic [DRAIN_CNT_W-1:0] drain_cnt;
    logic                   accept;
    logic                   draining;

    assign accept    = en && !acc_done;               // Beats offered after the last one are dropped
    assign draining  = acc_done && !systolic_finish;
    assign clear     = reset_acc;
    assign advance   = accept || draining;
    assign zero_fill = draining;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
            acc_done <= 1'b0;
        end else if (reset_acc) begin
            beat_cnt <= '0;
            acc_done <= 1'b0;
        end else if (accept) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == BEAT_CNT_W'(INNER_DIMENSION - 1)) begin
                acc_done <= 1'b1;  // Set on the edge taking the final beat
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drain_cnt       <= '0;
            systolic_finish <= 1'b0;
        end else if (reset_acc) begin
            drain_cnt       <= '0;
            systolic_finish <= 1'b0;
        end else if (draining) begin
            drain_cnt <= drain_cnt + 1'b1;
            if (drain_cnt == DRAIN_CNT_W'(DRAIN_CYCLES - 1)) begin
                systolic_finish <= 1'b1;
            end
        end
    end

endmodule

/* hdl/systolic_array.sv */
`timescale 1ns/1ps
// CHUNK_SIZE square grid of MAC cells with triangular input skew on the west and north edges
// The tile output is each accumulator scaled back to Q8.8 and clamped to the 16-bit range
module systolic_array (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clear,
    input  logic                   advance,
    input  logic                   zero_fill,
    input  matmul_pkg::chunk_vec_t west_vec,
    input  matmul_pkg::chunk_vec_t north_vec,
    output matmul_pkg::tile_t      tile
);
    import matmul_pkg::*;

    chunk_vec_t west_in;
    chunk_vec_t north_in;
    fixed_t     a_h [CHUNK_SIZE][CHUNK_SIZE+1];  // a_h[r][c] enters cell (r,c) from the west
    fixed_t     b_v [CHUNK_SIZE+1][CHUNK_SIZE];  // b_v[r][c] enters cell (r,c) from the north
    acc_t       pe_acc [CHUNK_SIZE][CHUNK_SIZE];

    assign west_in  = zero_fill ? '0 : west_vec;   // Drain flushes zeros behind the last beat
    assign north_in = zero_fill ? '0 : north_vec;

    // Lane i of both edges is delayed by i stages so operands meet on the diagonal
    for (genvar i = 0; i < CHUNK_SIZE; i++) begin : gen_skew
        if (i == 0) begin : gen_direct
            assign a_h[0][0] = west_in.elem[0];
            assign b_v[0][0] = north_in.elem[0];
        end else begin : gen_delay
            fixed_t [1:0] stage [i];  // Bit lane 0 is the west element, lane 1 the north one

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    for (int s = 0; s < i; s++) begin
                        stage[s] <= '0;
                    end
                end else if (clear) begin
                    for (int s = 0; s < i; s++) begin
                        stage[s] <= '0;
                    end
                end else if (advance) begin
                    stage[0] <= {north_in.elem[i], west_in.elem[i]};
                    for (int s = 1; s < i; s++) begin
                        stage[s] <= stage[s-1];
                    end
                end
            end

            assign a_h[i][0] = stage[i-1][0];
            assign b_v[0][i] = stage[i-1][1];
        end
    end

    for (genvar r = 0; r < CHUNK_SIZE; r++) begin : gen_row
        for (genvar c = 0; c < CHUNK_SIZE; c++) begin : gen_col
            mac_pe pe_inst (
                .clk     (clk),
                .arst_n  (arst_n),
                .clear   (clear),
                .advance (advance),
                .a_in    (a_h[r][c]),
                .b_in    (b_v[r][c]),
                .a_out   (a_h[r][c+1]),  // Edge outputs of the last column are left open
                .b_out   (b_v[r+1][c]),
                .acc     (pe_acc[r][c])
            );
        end
    end

    always_comb begin
        acc_t shifted;
        for (int r = 0; r < CHUNK_SIZE; r++) begin
            for (int c = 0; c < CHUNK_SIZE; c++) begin
                shifted = pe_acc[r][c] >>> FRAC_WIDTH;  // Q16.16 back to Q8.8
                if (shifted > SAT_HI) begin
                    tile.elem[r][c] = SAT_HI[WIDTH-1:0];
                end else if (shifted < SAT_LO) begin
                    tile.elem[r][c] = SAT_LO[WIDTH-1:0];
                end else begin
                    tile.elem[r][c] = shifted[WIDTH-1:0];
                end
            end
        end
    end

endmodule

/* hdl/mac_pe.sv */
`timescale 1ns/1ps
// One cell of the output-stationary grid
// Moves A east and B south by one register per advance and keeps the running dot product
module mac_pe (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               clear,
    input  logic               advance,
    input  matmul_pkg::fixed_t a_in,
    input  matmul_pkg::fixed_t b_in,
    output matmul_pkg::fixed_t a_out,
    output matmul_pkg::fixed_t b_out,
    output matmul_pkg::acc_t   acc
);
    import matmul_pkg::*;

    logic signed [2*WIDTH-1:0] product;  // Full Q16.16 product

    assign product = a_in * b_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (advance) begin
            a_out <= a_in;
            b_out <= b_in;
            acc   <= acc + product;  // Product is sign extended to the accumulator
        end
    end

endmodule

/* hdl/matmul_pkg.sv */
// Widths, counts and packed bus types shared by every block of the matmul engine
// Modules import it in their bodies and name its types with scoped names in their ports
package matmul_pkg;

    localparam int WIDTH           = 16;
    localparam int FRAC_WIDTH      = 8;                 // Q8.8 operands and results
    localparam int ACC_WIDTH       = 40;                // Headroom for INNER_DIMENSION Q16.16 sums
    localparam int CHUNK_SIZE      = 2;
    localparam int INNER_DIMENSION = 8;                 // Beats per product
    localparam int TOTAL_MODULES   = 2;
    localparam int TOTAL_INPUT_W   = 2;
    localparam int DRAIN_CYCLES    = 2*CHUNK_SIZE - 1;  // Cycles to flush the skewed data

    // Counter widths hold the terminal count itself
    localparam int BEAT_CNT_W  = $clog2(INNER_DIMENSION + 1);
    localparam int DRAIN_CNT_W = $clog2(DRAIN_CYCLES + 1);

    typedef logic signed [WIDTH-1:0]     fixed_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // Signed 16-bit range expressed at accumulator width
    localparam acc_t SAT_HI = (acc_t'(1) <<< (WIDTH - 1)) - acc_t'(1);
    localparam acc_t SAT_LO = -(acc_t'(1) <<< (WIDTH - 1));

    typedef struct packed {
        fixed_t [CHUNK_SIZE-1:0] elem;  // Element i feeds row i or column i
    } chunk_vec_t;

    typedef struct packed {
        chunk_vec_t [TOTAL_MODULES-1:0] chunk;  // One column-chunk of B per array
    } north_bus_t;

    typedef struct packed {
        chunk_vec_t [TOTAL_INPUT_W-1:0] chunk;  // One row-chunk of A per group
    } west_bus_t;

    typedef struct packed {
        fixed_t [CHUNK_SIZE-1:0][CHUNK_SIZE-1:0] elem;  // Indexed [row][column]
    } tile_t;

    typedef struct packed {
        tile_t [TOTAL_MODULES-1:0] tile;
    } group_out_t;

    typedef struct packed {
        group_out_t [TOTAL_INPUT_W-1:0] grp;
    } engine_out_t;

endpackage
